// ==== verilog/rv32iIsaPkg.sv ====
// RV32I encodings and instruction format views, imported by the decode stage modules
`default_nettype none

package rv32iIsaPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Major opcodes
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [6:0] {
        OP_R      = 7'b0110011,                   // Register-register ALU
        OP_LOAD   = 7'b0000011,                   // I-type loads
        OP_IMM    = 7'b0010011,                   // I-type ALU
        OP_JALR   = 7'b1100111,
        OP_STORE  = 7'b0100011,                   // S-type
        OP_BRANCH = 7'b1100011,                   // B-type
        OP_LUI    = 7'b0110111,
        OP_AUIPC  = 7'b0010111,
        OP_JAL    = 7'b1101111,                   // J-type
        OP_FENCE  = 7'b0001111,                   // FENCE and PAUSE
        OP_SYSTEM = 7'b1110011                    // ECALL and EBREAK
    } opcodeE;

    // ALU funct3, shared by R-type and I-type arithmetic
    localparam logic [2:0] F3_ADD_SUB = 3'b000;
    localparam logic [2:0] F3_SLL     = 3'b001;
    localparam logic [2:0] F3_SLT     = 3'b010;
    localparam logic [2:0] F3_SLTU    = 3'b011;
    localparam logic [2:0] F3_XOR     = 3'b100;
    localparam logic [2:0] F3_SRL_SRA = 3'b101;
    localparam logic [2:0] F3_OR      = 3'b110;
    localparam logic [2:0] F3_AND     = 3'b111;

    // Loads and stores
    localparam logic [2:0] F3_LB  = 3'b000;
    localparam logic [2:0] F3_LH  = 3'b001;
    localparam logic [2:0] F3_LW  = 3'b010;
    localparam logic [2:0] F3_LBU = 3'b100;
    localparam logic [2:0] F3_LHU = 3'b101;
    localparam logic [2:0] F3_SB  = 3'b000;
    localparam logic [2:0] F3_SH  = 3'b001;
    localparam logic [2:0] F3_SW  = 3'b010;

    // Branches and JALR
    localparam logic [2:0] F3_BEQ  = 3'b000;
    localparam logic [2:0] F3_BNE  = 3'b001;
    localparam logic [2:0] F3_BLT  = 3'b100;
    localparam logic [2:0] F3_BGE  = 3'b101;
    localparam logic [2:0] F3_BLTU = 3'b110;
    localparam logic [2:0] F3_BGEU = 3'b111;
    localparam logic [2:0] F3_JALR = 3'b000;

    localparam logic [6:0] F7_BASE = 7'b0000000;  // ADD, SRL and all others
    localparam logic [6:0] F7_ALT  = 7'b0100000;  // SUB, SRA, SRAI

    ////////////////////////////////////////////////////////////////////////////
    // Instruction formats, MSB first
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        opcodeE     opcode;
    } rTypeS;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        opcodeE      opcode;
    } iTypeS;

    typedef struct packed {
        logic [6:0] immHi;                        // imm[11:5]
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] immLo;                        // imm[4:0]
        opcodeE     opcode;
    } sTypeS;

    typedef struct packed {
        logic       imm12;
        logic [5:0] imm10to5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm4to1;
        logic       imm11;
        opcodeE     opcode;
    } bTypeS;

    typedef struct packed {
        logic [19:0] imm31to12;
        logic [4:0]  rd;
        opcodeE      opcode;
    } uTypeS;

    typedef struct packed {
        logic       imm20;
        logic [9:0] imm10to1;
        logic       imm11;
        logic [7:0] imm19to12;
        logic [4:0] rd;
        opcodeE     opcode;
    } jTypeS;

    typedef union packed {
        rTypeS r;
        iTypeS i;
        sTypeS s;
        bTypeS b;
        uTypeS u;
        jTypeS j;
    } instrU;

endpackage

`default_nettype wire

// ==== verilog/rv32iCtrlPkg.sv ====
// Control encodings and pipeline bundles passed between decode, execute and writeback
`default_nettype none

package rv32iCtrlPkg;

    ////////////////////////////////////////////////////////////////////////////
    // Control field encodings, zero is always the safe value
    ////////////////////////////////////////////////////////////////////////////
    typedef enum logic [3:0] {
        ALU_ADD  = 4'd0,
        ALU_SUB  = 4'd1,
        ALU_SLL  = 4'd2,
        ALU_BLT  = 4'd3,                          // Also SLT, SLTI
        ALU_BLTU = 4'd4,                          // Also SLTU, SLTIU
        ALU_XOR  = 4'd5,
        ALU_SRL  = 4'd6,
        ALU_SRA  = 4'd7,
        ALU_OR   = 4'd8,
        ALU_AND  = 4'd9,
        ALU_LUI  = 4'd10,                         // Pass source B
        ALU_BEQ  = 4'd11,
        ALU_BNE  = 4'd12,
        ALU_BGE  = 4'd13,
        ALU_BGEU = 4'd14
    } aluOpE;

    typedef enum logic [2:0] {
        MEM_BYTE   = 3'd0,
        MEM_HALF   = 3'd1,
        MEM_WORD   = 3'd2,
        MEM_BYTE_U = 3'd3,                        // Zero-extended loads
        MEM_HALF_U = 3'd4
    } memSizeE;

    typedef enum logic [2:0] {
        IMM_I = 3'd0,
        IMM_S = 3'd1,
        IMM_B = 3'd2,
        IMM_U = 3'd3,
        IMM_J = 3'd4
    } immTypeE;

    typedef enum logic [1:0] {
        RESULT_ALU = 2'd0,
        RESULT_MEM = 2'd1,
        RESULT_PC4 = 2'd2                         // Link value for JAL and JALR
    } resultSrcE;

    typedef enum logic {SRCA_REG = 1'b0, SRCA_PC = 1'b1} srcASelE;
    typedef enum logic {SRCB_REG = 1'b0, SRCB_IMM = 1'b1} srcBSelE;
    typedef enum logic {BRANCH_PC = 1'b0, BRANCH_REG = 1'b1} branchSrcSelE;  // Target base

    ////////////////////////////////////////////////////////////////////////////
    // Bundles
    ////////////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic         regWrEn;
        logic         memWrEn;
        logic         jumpEn;
        logic         branchEn;
        memSizeE      memSize;
        aluOpE        aluOp;
        srcASelE      srcASel;
        srcBSelE      srcBSel;
        branchSrcSelE branchSrcSel;
        resultSrcE    resultSrc;
    } ctrlS;

    typedef struct packed {
        ctrlS        ctrl;
        logic [31:0] pc;
        logic [4:0]  rd;
        logic [4:0]  rs1;                         // Kept for the hazard unit
        logic [4:0]  rs2;
        logic [31:0] rs1Data;
        logic [31:0] rs2Data;
        logic [31:0] imm;
    } idExS;

    typedef struct packed {
        logic        en;
        logic [4:0]  addr;
        logic [31:0] data;
    } wbS;

endpackage

`default_nettype wire

// ==== verilog/controlUnit.sv ====
// Combinational RV32I decoder that turns opcode, funct3 and funct7 into the control bundle
`default_nettype none

module controlUnit
    import rv32iIsaPkg::*;
    import rv32iCtrlPkg::*;
(
    input  wire instrU instr,
    output ctrlS       ctrl,
    output immTypeE    immType
);

    // All enables off, ADD, register sources, ALU result
    localparam ctrlS ctrlNop = '{
        regWrEn:      1'b0,
        memWrEn:      1'b0,
        jumpEn:       1'b0,
        branchEn:     1'b0,
        memSize:      MEM_BYTE,
        aluOp:        ALU_ADD,
        srcASel:      SRCA_REG,
        srcBSel:      SRCB_REG,
        branchSrcSel: BRANCH_PC,
        resultSrc:    RESULT_ALU
    };

    logic [2:0] f3;
    logic       f7Base;
    logic       f7Alt;
    logic       legal;                            // Cleared by any bad field

    assign f3     = instr.r.funct3;
    assign f7Base = (instr.r.funct7 == F7_BASE);
    assign f7Alt  = (instr.r.funct7 == F7_ALT);

    always_comb
    begin
        legal   = 1'b1;
        ctrl    = ctrlNop;
        immType = IMM_I;
        case (instr.r.opcode)
            OP_R:
            begin
                ctrl.regWrEn = 1'b1;
                case (f3)
                    F3_ADD_SUB: ctrl.aluOp = f7Alt ? ALU_SUB : ALU_ADD;
                    F3_SLL:     ctrl.aluOp = ALU_SLL;
                    F3_SLT:     ctrl.aluOp = ALU_BLT;     // Same compare as BLT
                    F3_SLTU:    ctrl.aluOp = ALU_BLTU;
                    F3_XOR:     ctrl.aluOp = ALU_XOR;
                    F3_SRL_SRA: ctrl.aluOp = f7Alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      ctrl.aluOp = ALU_OR;
                    F3_AND:     ctrl.aluOp = ALU_AND;
                endcase
                // Alternate funct7 only valid for SUB and SRA
                legal = f7Base || (f7Alt && (f3 == F3_ADD_SUB || f3 == F3_SRL_SRA));
            end
            OP_IMM:
            begin
                ctrl.regWrEn = 1'b1;
                ctrl.srcBSel = SRCB_IMM;
                case (f3)
                    F3_ADD_SUB: ctrl.aluOp = ALU_ADD;     // No SUBI exists
                    F3_SLL:     ctrl.aluOp = ALU_SLL;
                    F3_SLT:     ctrl.aluOp = ALU_BLT;
                    F3_SLTU:    ctrl.aluOp = ALU_BLTU;
                    F3_XOR:     ctrl.aluOp = ALU_XOR;
                    F3_SRL_SRA: ctrl.aluOp = f7Alt ? ALU_SRA : ALU_SRL;
                    F3_OR:      ctrl.aluOp = ALU_OR;
                    F3_AND:     ctrl.aluOp = ALU_AND;
                endcase
                // Shift amounts sit in imm[4:0] and the upper imm bits act as funct7
                if (f3 == F3_SLL)
                    legal = f7Base;
                else if (f3 == F3_SRL_SRA)
                    legal = f7Base || f7Alt;
            end
            OP_LOAD:
            begin
                ctrl.regWrEn   = 1'b1;
                ctrl.srcBSel   = SRCB_IMM;                // rs1 + offset
                ctrl.resultSrc = RESULT_MEM;
                case (f3)
                    F3_LB:   ctrl.memSize = MEM_BYTE;
                    F3_LH:   ctrl.memSize = MEM_HALF;
                    F3_LW:   ctrl.memSize = MEM_WORD;
                    F3_LBU:  ctrl.memSize = MEM_BYTE_U;
                    F3_LHU:  ctrl.memSize = MEM_HALF_U;
                    default: legal = 1'b0;
                endcase
            end
            OP_STORE:
            begin
                ctrl.memWrEn = 1'b1;
                ctrl.srcBSel = SRCB_IMM;
                immType      = IMM_S;
                case (f3)
                    F3_SB:   ctrl.memSize = MEM_BYTE;
                    F3_SH:   ctrl.memSize = MEM_HALF;
                    F3_SW:   ctrl.memSize = MEM_WORD;
                    default: legal = 1'b0;
                endcase
            end
            OP_BRANCH:
            begin
                ctrl.branchEn = 1'b1;                     // Compare rs1 with rs2
                immType       = IMM_B;
                case (f3)
                    F3_BEQ:  ctrl.aluOp = ALU_BEQ;
                    F3_BNE:  ctrl.aluOp = ALU_BNE;
                    F3_BLT:  ctrl.aluOp = ALU_BLT;
                    F3_BGE:  ctrl.aluOp = ALU_BGE;
                    F3_BLTU: ctrl.aluOp = ALU_BLTU;
                    F3_BGEU: ctrl.aluOp = ALU_BGEU;
                    default: legal = 1'b0;                // 010 and 011 unused
                endcase
            end
            OP_JALR:
            begin
                ctrl.regWrEn      = 1'b1;
                ctrl.jumpEn       = 1'b1;
                ctrl.srcBSel      = SRCB_IMM;
                ctrl.branchSrcSel = BRANCH_REG;           // Target from rs1 + imm
                ctrl.resultSrc    = RESULT_PC4;
                legal             = (f3 == F3_JALR);
            end
            OP_JAL:
            begin
                ctrl.regWrEn   = 1'b1;
                ctrl.jumpEn    = 1'b1;
                ctrl.resultSrc = RESULT_PC4;              // Link to rd
                immType        = IMM_J;
            end
            OP_LUI:
            begin
                ctrl.regWrEn = 1'b1;
                ctrl.aluOp   = ALU_LUI;
                ctrl.srcBSel = SRCB_IMM;
                immType      = IMM_U;
            end
            OP_AUIPC:
            begin
                ctrl.regWrEn = 1'b1;
                ctrl.srcASel = SRCA_PC;                   // PC + upper immediate
                ctrl.srcBSel = SRCB_IMM;
                immType      = IMM_U;
            end
            default: legal = 1'b0;                        // FENCE, SYSTEM and unknown opcodes
        endcase

        if (!legal)
            ctrl = ctrlNop;                               // Nothing may change state
    end

endmodule

`default_nettype wire

// ==== verilog/registerFile.sv ====
// Two-read one-write register file with x0 tied to zero and writeback forwarding
`default_nettype none

module registerFile
    import rv32iCtrlPkg::*;
#(
    parameter int regCount = 32                   // 16 for RV32E
)
(
    input  wire        CLK,
    input  wire  [4:0] rs1Addr,
    input  wire  [4:0] rs2Addr,
    input  wire  wbS   wb,
    output logic [31:0] rs1Data,
    output logic [31:0] rs2Data
);

    logic [31:0] regs [regCount];                 // One word per architectural register

    // Zero for x0 and missing registers, then same-cycle write, then array
    function automatic logic [31:0] readReg(input logic [4:0] addr);
        if (addr == 5'd0 || int'(addr) >= regCount)
            return 32'd0;
        else if (wb.en && wb.addr == addr)
            return wb.data;                       // Bypass this cycle's write
        else
            return regs[addr];
    endfunction

    always_ff @(posedge CLK)
    begin
        if (wb.en && wb.addr != 5'd0 && int'(wb.addr) < regCount)
            regs[wb.addr] <= wb.data;
    end

    always_comb
    begin
        rs1Data = readReg(rs1Addr);
        rs2Data = readReg(rs2Addr);
    end

endmodule

`default_nettype wire

// ==== verilog/immediateExtender.sv ====
// Assembles the 32-bit immediate from the instruction word for the selected format
`default_nettype none

module immediateExtender
    import rv32iIsaPkg::*;
    import rv32iCtrlPkg::*;
(
    input  wire instrU   instr,
    input  wire immTypeE immType,
    output logic [31:0]  imm
);

    always_comb
    begin
        case (immType)
            IMM_I: imm = {{20{instr.i.imm[11]}}, instr.i.imm};
            IMM_S: imm = {{20{instr.s.immHi[6]}}, instr.s.immHi, instr.s.immLo};
            IMM_B: imm = {{20{instr.b.imm12}}, instr.b.imm11, instr.b.imm10to5,
                          instr.b.imm4to1, 1'b0};                 // Halfword offset
            IMM_U: imm = {instr.u.imm31to12, 12'd0};               // Upper 20 bits
            IMM_J: imm = {{12{instr.j.imm20}}, instr.j.imm19to12, instr.j.imm11,
                          instr.j.imm10to1, 1'b0};
            default: imm = 32'd0;                                  // Unused codes
        endcase
    end

endmodule

`default_nettype wire

// ==== verilog/idExRegister.sv ====
// ID/EX pipeline register, loads the decoded bundle with stall hold and flush to bubble
`default_nettype none

module idExRegister
    import rv32iCtrlPkg::*;
(
    input  wire       CLK,
    input  wire       arstN,
    input  wire       stall,                      // Hold, from hazard unit
    input  wire       flush,                      // Bubble, wins over stall
    input  wire idExS nextBundle,
    output idExS      ex
);

    ////////////////////////////////////////////////////////////////////////////
    // An all-zero bundle is a bubble: no enables, ADD, register sources
    ////////////////////////////////////////////////////////////////////////////
    always_ff @(posedge CLK or negedge arstN)
    begin
        if (!arstN)
        begin
            ex <= '0;
        end
        else if (flush)
        begin
            ex <= '0;                             // Squash wrong-path instruction
        end
        else if (!stall)
        begin
            ex <= nextBundle;                     // Normal advance
        end
    end

endmodule

`default_nettype wire

// ==== verilog/decodeStage.sv ====
// RV32I decode stage top level, joins decoder, register file, extender and ID/EX register
`default_nettype none

module decodeStage
    import rv32iIsaPkg::*;
    import rv32iCtrlPkg::*;
#(
    parameter int regCount = 32                   // Passed to the register file
)
(
    input  wire              CLK,
    input  wire              arstN,
    input  wire instrU       instrD,              // Held by fetch
    input  wire       [31:0] pcD,
    input  wire wbS          wb,                  // One cycle per write
    input  wire              stall,
    input  wire              flush,
    output idExS             ex
);

    ctrlS        ctrl;
    immTypeE     immType;
    logic [31:0] rs1Data;
    logic [31:0] rs2Data;
    logic [31:0] imm;
    idExS        nextBundle;

    controlUnit uControl (
        .instr   (instrD),
        .ctrl    (ctrl),
        .immType (immType)
    );

    registerFile #(
        .regCount (regCount)
    ) uRegFile (
        .CLK     (CLK),
        .rs1Addr (instrD.r.rs1),                  // Same position in every format
        .rs2Addr (instrD.r.rs2),
        .wb      (wb),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    immediateExtender uImmExt (
        .instr   (instrD),
        .immType (immType),
        .imm     (imm)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Next ID/EX contents
    ////////////////////////////////////////////////////////////////////////////
    always_comb
    begin
        nextBundle.ctrl    = ctrl;
        nextBundle.pc      = pcD;
        nextBundle.rd      = instrD.r.rd;
        nextBundle.rs1     = instrD.r.rs1;        // Raw fields for hazard detection
        nextBundle.rs2     = instrD.r.rs2;
        nextBundle.rs1Data = rs1Data;
        nextBundle.rs2Data = rs2Data;
        nextBundle.imm     = imm;
    end

    idExRegister uIdEx (
        .CLK        (CLK),
        .arstN      (arstN),
        .stall      (stall),
        .flush      (flush),
        .nextBundle (nextBundle),
        .ex         (ex)
    );

endmodule

`default_nettype wire

// ==== testbench/decodeStage_asserts.sv ====
// Concurrent checks on the ID/EX register, bound into every idExRegister instance
`default_nettype none

module decodeStageAsserts
    import rv32iCtrlPkg::*;
(
    input wire       CLK,
    input wire       arstN,
    input wire       stall,
    input wire       flush,
    input wire idExS ex
);

    // Register held clear while reset is low
    resetBubble: assert property (@(posedge CLK) !arstN |-> ex == '0)
        else $error("ID/EX not a bubble during reset");

    // Flush at the previous edge leaves a bubble
    flushBubble: assert property (@(posedge CLK) disable iff (!arstN)
        $past(flush) |-> ex == '0)
        else $error("ID/EX not a bubble after flush");

    // Stall without flush keeps the old bundle
    stallHold: assert property (@(posedge CLK) disable iff (!arstN)
        ($past(stall) && !$past(flush)) |-> ex == $past(ex))
        else $error("ID/EX changed during stall");

    // x0 always reads as zero
    zeroRegRead: assert property (@(posedge CLK) disable iff (!arstN)
        ex.rs1 == 5'd0 |-> ex.rs1Data == 32'd0)
        else $error("rs1Data nonzero for x0");

endmodule

bind idExRegister decodeStageAsserts uAsserts (
    .CLK   (CLK),
    .arstN (arstN),
    .stall (stall),
    .flush (flush),
    .ex    (ex)
);

`default_nettype wire

// ==== testbench/decodeStageTb.sv ====
// Decode stage testbench that replays the vector file and checks the ID/EX bundle
`default_nettype none

module decodeStageTb;
    import rv32iIsaPkg::*;
    import rv32iCtrlPkg::*;

    localparam int    numVectors   = 37;
    localparam int    wordsPerVec  = 15;              // 7 stimulus, 8 expected
    localparam int    maxCycles    = 200;             // Watchdog limit
    localparam int    maxVecCycles = 60;              // Vector loop limit
    localparam logic [31:0] endMarker = 32'he0f0e0f0;
    localparam string vectorPath   = "testbench/decodeStage_vectors.txt";

    logic        CLK;
    logic        arstN;
    instrU       instrD;
    logic [31:0] pcD;
    wbS          wb;
    logic        stall;
    logic        flush;
    idExS        ex;

    logic [31:0] vecMem [0:numVectors*wordsPerVec];   // Last word is the end marker
    int          fd;
    int          vecIdx;
    int          base;
    int          loopCycles;

    decodeStage #(
        .regCount (32)
    ) uut (
        .CLK    (CLK),
        .arstN  (arstN),
        .instrD (instrD),
        .pcD    (pcD),
        .wb     (wb),
        .stall  (stall),
        .flush  (flush),
        .ex     (ex)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Clock and watchdog
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        CLK = 1'b0;
        forever #50 CLK = ~CLK;                       // Period 100
    end

    initial
    begin : watchdog
        int count;
        for (count = 0; count < maxCycles; count++)
            @(posedge CLK);
        $display("run did not finish within %0d clock cycles", maxCycles);
        $display("Testbench failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////////////////////
    task automatic checkValue(input string name, input logic [31:0] actual,
                              input logic [31:0] expected);
        if (actual !== expected)
        begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Testbench failed");
            $fatal(1, "value check stopped the run");
        end
    endtask

    // One rising edge and back to the falling edge where inputs change
    task automatic stepCycle();
        @(posedge CLK);
        @(negedge CLK);
        loopCycles++;
        if (loopCycles > maxVecCycles)
        begin
            $display("vector loop ran longer than %0d cycles", maxVecCycles);
            $display("Testbench failed");
            $fatal(1, "vector loop timeout");
        end
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////
    initial
    begin
        arstN      = 1'b0;
        instrD     = '0;
        pcD        = 32'd0;
        wb         = '0;
        stall      = 1'b0;
        flush      = 1'b0;
        loopCycles = 0;
        for (int k = 0; k <= numVectors*wordsPerVec; k++)
            vecMem[k] = k;                            // Never equals the end marker

        fd = $fopen(vectorPath, "r");
        if (fd == 0)
        begin
            $display("vector file %s could not be opened", vectorPath);
            $display("Testbench failed");
            $fatal(1, "missing vector file");
        end
        $fclose(fd);
        $readmemh(vectorPath, vecMem);
        if (vecMem[numVectors*wordsPerVec] !== endMarker)
        begin
            $display("vector file holds fewer than %0d vectors", numVectors);
            $display("Testbench failed");
            $fatal(1, "short vector file");
        end

        repeat (4) @(posedge CLK);                    // Four reset cycles
        @(negedge CLK);
        checkValue("ex.ctrl after reset", {16'd0, ex.ctrl}, 32'd0);
        checkValue("ex.rd after reset", {27'd0, ex.rd}, 32'd0);
        checkValue("ex.imm after reset", ex.imm, 32'd0);
        arstN = 1'b1;

        for (vecIdx = 0; vecIdx < numVectors; vecIdx++)
        begin
            base   = vecIdx * wordsPerVec;
            instrD = vecMem[base];
            pcD    = vecMem[base+1];
            wb.en   = vecMem[base+2][0];
            wb.addr = vecMem[base+3][4:0];
            wb.data = vecMem[base+4];
            stall  = vecMem[base+5][0];
            flush  = vecMem[base+6][0];
            stepCycle();
            checkValue("ex.ctrl", {16'd0, ex.ctrl}, vecMem[base+7]);
            checkValue("ex.pc", ex.pc, vecMem[base+8]);
            checkValue("ex.rd", {27'd0, ex.rd}, vecMem[base+9]);
            checkValue("ex.rs1", {27'd0, ex.rs1}, vecMem[base+10]);
            checkValue("ex.rs2", {27'd0, ex.rs2}, vecMem[base+11]);
            checkValue("ex.rs1Data", ex.rs1Data, vecMem[base+12]);
            checkValue("ex.rs2Data", ex.rs2Data, vecMem[base+13]);
            checkValue("ex.imm", ex.imm, vecMem[base+14]);
        end

        $display("Testbench passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== testbench/decodeStage_vectors.txt ====
// instr pc wbEn wbAddr wbData stall flush | expected ex: ctrl pc rd rs1 rs2 rs1Data rs2Data imm
// ctrl is {regWr, memWr, jump, branch, memSize[2:0], aluOp[3:0], srcA, srcB, brSrc, result[1:0]}
00000013 00000100 1 1f 31313131 0 0 8008 00000100 00 00 00 00000000 00000000 00000000
000081b3 00000104 1 01 11111111 0 0 8000 00000104 03 01 00 11111111 00000000 00000000
40208233 00000108 1 02 00000022 0 0 8020 00000108 04 01 02 11111111 00000022 00000402
001012b3 0000010c 1 00 deadbeef 0 0 8040 0000010c 05 00 01 00000000 11111111 00000001
0020a333 00000110 0 00 00000000 0 0 8060 00000110 06 01 02 11111111 00000022 00000002
4020d3b3 00000114 1 08 ffffff80 0 0 80e0 00000114 07 01 02 11111111 00000022 00000402
fff08493 00000118 0 00 00000000 0 0 8008 00000118 09 01 1f 11111111 31313131 ffffffff
80043513 0000011c 0 00 00000000 0 0 8088 0000011c 0a 08 00 ffffff80 00000000 fffff800
40245593 00000120 0 00 00000000 0 0 80e8 00000120 0b 08 02 ffffff80 00000022 00000402
fe008603 00000124 0 00 00000000 0 0 8009 00000124 0c 01 00 11111111 00000000 ffffffe0
00811683 00000128 0 00 00000000 0 0 8209 00000128 0d 02 08 00000022 ffffff80 00000008
0010a703 0000012c 0 00 00000000 0 0 8409 0000012c 0e 01 01 11111111 11111111 00000001
00204783 00000130 0 00 00000000 0 0 8609 00000130 0f 00 02 00000000 00000022 00000002
00045803 00000134 0 00 00000000 0 0 8809 00000134 10 08 00 ffffff80 00000000 00000000
fe208fa3 00000138 0 00 00000000 0 0 4008 00000138 1f 01 02 11111111 00000022 ffffffff
00811323 0000013c 0 00 00000000 0 0 4208 0000013c 06 02 08 00000022 ffffff80 00000006
81f02023 00000140 0 00 00000000 0 0 4408 00000140 00 00 1f 00000000 31313131 fffff800
00100863 00000144 0 00 00000000 0 0 1160 00000144 10 00 01 00000000 11111111 00000010
fe209ee3 00000148 0 00 00000000 0 0 1180 00000148 1d 01 02 11111111 00000022 fffffffc
002440e3 0000014c 0 00 00000000 0 0 1060 0000014c 01 08 02 ffffff80 00000022 00000800
8000d063 00000150 0 00 00000000 0 0 11a0 00000150 00 01 00 11111111 00000000 fffff000
00116463 00000154 0 00 00000000 0 0 1080 00000154 08 02 01 00000022 11111111 00000008
028ff063 00000158 0 00 00000000 0 0 11c0 00000158 00 1f 08 31313131 ffffff80 00000020
800018b7 0000015c 0 00 00000000 0 0 8148 0000015c 11 00 00 00000000 00000000 80001000
fffff917 00000160 0 00 00000000 0 0 8018 00000160 12 1f 1f 31313131 31313131 fffff000
fffff0ef 00000164 0 00 00000000 0 0 a002 00000164 01 1f 1f 31313131 31313131 fffffffe
fe0102e7 00000168 0 00 00000000 0 0 a00e 00000168 05 02 00 00000022 00000000 ffffffe0
0ff0000f 0000016c 0 00 00000000 0 0 0000 0000016c 00 00 1f 00000000 31313131 000000ff
00000073 00000170 0 00 00000000 0 0 0000 00000170 00 00 00 00000000 00000000 00000000
0000007f 00000174 0 00 00000000 0 0 0000 00000174 00 00 00 00000000 00000000 00000000
022081b3 00000178 0 00 00000000 0 0 0000 00000178 03 01 02 11111111 00000022 00000022
000081b3 0000017c 0 00 00000000 0 0 8000 0000017c 03 01 00 11111111 00000000 00000000
40208233 00000180 0 00 00000000 1 0 8000 0000017c 03 01 00 11111111 00000000 00000000
0010a703 00000184 0 00 00000000 1 0 8000 0000017c 03 01 00 11111111 00000000 00000000
001012b3 00000188 0 00 00000000 1 1 0000 00000000 00 00 00 00000000 00000000 00000000
800018b7 0000018c 0 00 00000000 0 1 0000 00000000 00 00 00 00000000 00000000 00000000
fff08493 00000190 1 01 cafef00d 0 0 8008 00000190 09 01 1f cafef00d 31313131 ffffffff
// End marker
e0f0e0f0

// ==== rv32iDecode.f ====
verilog/rv32iIsaPkg.sv
verilog/rv32iCtrlPkg.sv
verilog/controlUnit.sv
verilog/registerFile.sv
verilog/immediateExtender.sv
verilog/idExRegister.sv
verilog/decodeStage.sv
testbench/decodeStage_asserts.sv
testbench/decodeStageTb.sv

// ==== Makefile ====
# Verilator build, run, lint and clean for the RV32I decode stage

VERILATOR ?= verilator
TOP       ?= decodeStageTb
FILELIST  ?= rv32iDecode.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJ_DIR)
